// ==== hv_consts.svh ====
`ifndef HV_CONSTS_SVH
`define HV_CONSTS_SVH

// hypervector width
`define HV_DIM        256

// load stream, 32-bit words filling a vector from the bottom
`define HV_WORD       32
`define HV_WORDS      8
`define HV_WORD_IDX_W 3

// item memory depth and address
`define HV_ITEMS      64
`define HV_ADDR_W     6

// round-robin threads
`define HV_THREADS    5
`define HV_THREAD_W   3

// instruction argument, also the rotate amount
`define HV_ARG_W      8

`endif

// ==== hv_pkg.sv ====
`include "hv_consts.svh"

package hv_pkg;

    // one operation per instruction
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_LOAD  = 3'd1,
        OP_ROT   = 3'd2,
        OP_BIND  = 3'd3,
        OP_COPY  = 3'd4,
        OP_STORE = 3'd5,
        OP_LAST  = 3'd6
    } hv_op_e;

    // arg low bits give the item address for OP_LOAD
    // and the rotate-left amount for OP_ROT
    typedef struct packed {
        hv_op_e                 op;
        logic [`HV_ARG_W-1:0]   arg;
    } hv_inst_t;

    // item memory write request, en is a single-cycle strobe
    typedef struct packed {
        logic                   en;
        logic [`HV_ADDR_W-1:0]  addr;
        logic [`HV_DIM-1:0]     vec;
    } hv_item_wr_t;

    // core output, vec is zero unless store is high
    typedef struct packed {
        logic                   store;
        logic                   last;
        logic [`HV_DIM-1:0]     vec;
    } hv_result_t;

endpackage

// ==== hv_item_loader.sv ====
`timescale 1ns/1ps

`include "hv_consts.svh"

module hv_item_loader (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    com,
    input  logic                    word_valid,
    input  logic [`HV_WORD-1:0]     word_data,
    output hv_pkg::hv_item_wr_t     item_wr
);

    localparam logic [`HV_WORD_IDX_W-1:0] LAST_WORD = `HV_WORD_IDX_W'(`HV_WORDS - 1);

    logic [`HV_WORD_IDX_W-1:0]  word_idx;
    logic [`HV_ADDR_W-1:0]      item_addr;
    logic                       wr_en;
    logic [`HV_DIM-1:0]         asm_vec;

    // word counter, item address and write strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_idx  <= '0;
            item_addr <= '0;
            wr_en     <= 1'b0;
        end else if (!com) begin
            word_idx  <= '0;
            item_addr <= '0;
            wr_en     <= 1'b0;
        end else begin
            // strobe follows the last word of a vector
            wr_en <= word_valid && (word_idx == LAST_WORD);
            if (word_valid) begin
                if (word_idx == LAST_WORD) begin
                    word_idx <= '0;
                end else begin
                    word_idx <= word_idx + 1'b1;
                end
            end
            // next item once the current one is written, wraps at 64
            if (wr_en) begin
                item_addr <= item_addr + 1'b1;
            end
        end
    end

    // assembly register, each word lands in its own slice
    always_ff @(posedge clk) begin
        if (com && word_valid) begin
            asm_vec[word_idx*`HV_WORD +: `HV_WORD] <= word_data;
        end
    end

    assign item_wr = '{en: wr_en, addr: item_addr, vec: asm_vec};

endmodule

// ==== hv_item_memory.sv ====
`timescale 1ns/1ps

`include "hv_consts.svh"

module hv_item_memory (
    input  logic                    clk,
    input  hv_pkg::hv_item_wr_t     item_wr,
    input  logic [`HV_ADDR_W-1:0]   rd_addr,
    output logic [`HV_DIM-1:0]      rd_vec
);

    // item vectors
    logic [`HV_DIM-1:0] mem [`HV_ITEMS];

    // write from the loader
    always_ff @(posedge clk) begin
        if (item_wr.en) begin
            mem[item_wr.addr] <= item_wr.vec;
        end
    end

    // registered read every cycle, data one clock after the address
    always_ff @(posedge clk) begin
        rd_vec <= mem[rd_addr];
    end

endmodule

// ==== hv_exec_core.sv ====
`timescale 1ns/1ps

`include "hv_consts.svh"

module hv_exec_core (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    run,
    input  logic                    inst_valid,
    input  hv_pkg::hv_inst_t        inst,
    output logic [`HV_ADDR_W-1:0]   rd_addr,
    input  logic [`HV_DIM-1:0]      rd_vec,
    output hv_pkg::hv_result_t      result
);

    import hv_pkg::*;

    localparam logic [`HV_THREAD_W-1:0] LAST_THREAD = `HV_THREAD_W'(`HV_THREADS - 1);

    // thread that owns the next accepted instruction
    logic [`HV_THREAD_W-1:0]    thread_cnt;

    // stage 1
    logic                       s1_valid;
    hv_inst_t                   s1_inst;
    logic [`HV_THREAD_W-1:0]    s1_thread;

    // stage 2
    logic                       s2_valid;
    hv_inst_t                   s2_inst;
    logic [`HV_THREAD_W-1:0]    s2_thread;
    logic [`HV_DIM-1:0]         s2_acc;
    logic [`HV_DIM-1:0]         s2_aux;

    // per-thread vector registers
    logic [`HV_DIM-1:0]         acc_regs [`HV_THREADS];
    logic [`HV_DIM-1:0]         aux_regs [`HV_THREADS];

    // execute
    logic                       exec_valid;
    logic [2*`HV_DIM-1:0]       rot_wide;
    logic [`HV_DIM-1:0]         acc_next;
    logic                       acc_we;
    logic                       aux_we;
    hv_result_t                 result_next;

    // round robin over the threads, restarts at 0 with run
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            thread_cnt <= '0;
        end else if (!run) begin
            thread_cnt <= '0;
        end else if (inst_valid) begin
            if (thread_cnt == LAST_THREAD) begin
                thread_cnt <= '0;
            end else begin
                thread_cnt <= thread_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= run & inst_valid;
            s2_valid <= run & s1_valid;
        end
    end

    // payload of both stages, thread registers read here
    always_ff @(posedge clk) begin
        s1_inst   <= inst;
        s1_thread <= thread_cnt;
        s2_inst   <= s1_inst;
        s2_thread <= s1_thread;
        s2_acc    <= acc_regs[s1_thread];
        s2_aux    <= aux_regs[s1_thread];
    end

    // item read issued from stage 1 so rd_vec lines up with stage 2
    assign rd_addr = s1_inst.arg[`HV_ADDR_W-1:0];

    assign exec_valid = run & s2_valid;

    always_comb begin
        // rotate left through a doubled copy
        rot_wide    = {s2_acc, s2_acc} << s2_inst.arg;
        acc_next    = s2_acc;
        acc_we      = 1'b0;
        aux_we      = 1'b0;
        result_next = '0;
        if (exec_valid) begin
            case (s2_inst.op)
                OP_LOAD: begin
                    acc_next = rd_vec;
                    acc_we   = 1'b1;
                end
                OP_ROT: begin
                    acc_next = rot_wide[2*`HV_DIM-1 -: `HV_DIM];
                    acc_we   = 1'b1;
                end
                OP_BIND: begin
                    acc_next = s2_acc ^ s2_aux;
                    acc_we   = 1'b1;
                end
                OP_COPY: begin
                    aux_we = 1'b1;
                end
                OP_STORE: begin
                    result_next.store = 1'b1;
                    result_next.vec   = s2_acc;
                end
                OP_LAST: begin
                    result_next.last = 1'b1;
                end
                default: begin
                    // nop keeps everything
                end
            endcase
        end
    end

    // write-back to the owning thread
    always_ff @(posedge clk) begin
        if (acc_we) begin
            acc_regs[s2_thread] <= acc_next;
        end
        if (aux_we) begin
            aux_regs[s2_thread] <= s2_acc;
        end
    end

    // output register, zero outside store and last cycles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else begin
            result <= result_next;
        end
    end

endmodule

// ==== hv_core_top.sv ====
`timescale 1ns/1ps

`include "hv_consts.svh"

module hv_core_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    com,
    input  logic                    word_valid,
    input  logic [`HV_WORD-1:0]     word_data,
    input  logic                    run,
    input  logic                    inst_valid,
    input  hv_pkg::hv_inst_t        inst,
    output hv_pkg::hv_result_t      result
);

    import hv_pkg::*;

    // loader to memory
    hv_item_wr_t                item_wr;

    // core to memory and back
    logic [`HV_ADDR_W-1:0]      rd_addr;
    logic [`HV_DIM-1:0]         rd_vec;

    // word stream to item vectors
    hv_item_loader u_loader (
        .clk        (clk),
        .arst_n     (arst_n),
        .com        (com),
        .word_valid (word_valid),
        .word_data  (word_data),
        .item_wr    (item_wr)
    );

    hv_item_memory u_mem (
        .clk        (clk),
        .item_wr    (item_wr),
        .rd_addr    (rd_addr),
        .rd_vec     (rd_vec)
    );

    // threaded execution and result output
    hv_exec_core u_core (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rd_addr    (rd_addr),
        .rd_vec     (rd_vec),
        .result     (result)
    );

endmodule

// ==== tb_hv_model.svh ====
`ifndef TB_HV_MODEL_SVH
`define TB_HV_MODEL_SVH

`include "hv_consts.svh"

// reference copy of the item memory
logic [`HV_DIM-1:0] model_item [`HV_ITEMS];

// reference copy of the per-thread vector registers
logic [`HV_DIM-1:0] model_acc [`HV_THREADS];
logic [`HV_DIM-1:0] model_aux [`HV_THREADS];

// thread that owns the next accepted instruction
int unsigned model_thread;

// bit i moves to bit i+amt, wrapping at the top
function automatic logic [`HV_DIM-1:0] rotate_left(input logic [`HV_DIM-1:0] v,
                                                   input int unsigned amt);
    logic [`HV_DIM-1:0] r;
    for (int i = 0; i < `HV_DIM; i++) begin
        r[(i + amt) % `HV_DIM] = v[i];
    end
    return r;
endfunction

// applies one instruction in program order and returns the result it produces
function automatic hv_result_t model_exec(input hv_op_e op, input logic [`HV_ARG_W-1:0] arg);
    hv_result_t  res;
    int unsigned t;
    res = '0;
    t   = model_thread;
    case (op)
        OP_LOAD: begin
            model_acc[t] = model_item[arg[`HV_ADDR_W-1:0]];
        end
        OP_ROT: begin
            model_acc[t] = rotate_left(model_acc[t], arg);
        end
        OP_BIND: begin
            model_acc[t] = model_acc[t] ^ model_aux[t];
        end
        OP_COPY: begin
            model_aux[t] = model_acc[t];
        end
        OP_STORE: begin
            res.store = 1'b1;
            res.vec   = model_acc[t];
        end
        OP_LAST: begin
            res.last = 1'b1;
        end
        default: begin
        end
    endcase
    model_thread = (model_thread + 1) % `HV_THREADS;
    return res;
endfunction

`endif

// ==== tb_hv_core.sv ====
`timescale 1ns/1ps

`include "hv_consts.svh"

module tb_hv_core;

    import hv_pkg::*;

    `include "tb_hv_model.svh"

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 16;
    localparam int DRAIN_TIMEOUT = 20;

    logic                   clk;
    logic                   arst_n;
    logic                   com;
    logic                   word_valid;
    logic [`HV_WORD-1:0]    word_data;
    logic                   run;
    logic                   inst_valid;
    hv_inst_t               inst;
    hv_result_t             result;

    // levels applied to com and run at the next falling edge
    logic                   com_req;
    logic                   run_req;

    // expected output per cycle, checked three falling edges after the drive
    hv_result_t             exp_q[$];
    int unsigned            busy_cycles;

    hv_core_top u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .com        (com),
        .word_valid (word_valid),
        .word_data  (word_data),
        .run        (run),
        .inst_valid (inst_valid),
        .inst       (inst),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [`HV_DIM-1:0] exp_val,
                               input logic [`HV_DIM-1:0] act_val);
        if (act_val !== exp_val) begin
            fail_run($sformatf("Mismatch at %0t: %s expected %h, got %h",
                               $time, name, exp_val, act_val));
        end
    endtask

    // one clock: check the outputs, then drive the inputs and step the model
    task automatic tick(input logic wv, input logic [`HV_WORD-1:0] wd, input logic iv,
                        input hv_op_e op, input logic [`HV_ARG_W-1:0] arg);
        hv_result_t exp_res;
        hv_result_t next_res;
        @(negedge clk);
        exp_res = exp_q.pop_front();
        check_value("result.store", `HV_DIM'(exp_res.store), `HV_DIM'(result.store));
        check_value("result.last", `HV_DIM'(exp_res.last), `HV_DIM'(result.last));
        check_value("result.vec", exp_res.vec, result.vec);
        com        = com_req;
        run        = run_req;
        word_valid = wv;
        word_data  = wd;
        inst_valid = iv;
        inst       = '{op: op, arg: arg};
        next_res   = '0;
        if (busy_cycles > 0) begin
            busy_cycles--;
        end
        // thread counter restarts while run is low
        if (!run_req) begin
            model_thread = 0;
        end else if (iv) begin
            next_res    = model_exec(op, arg);
            busy_cycles = 3;
        end
        exp_q.push_back(next_res);
    endtask

    task automatic idle();
        tick(1'b0, '0, 1'b0, OP_NOP, '0);
    endtask

    task automatic issue(input hv_op_e op, input logic [`HV_ARG_W-1:0] arg);
        tick(1'b0, '0, 1'b1, op, arg);
    endtask

    task automatic random_gap(input int unsigned max_gap);
        repeat ($urandom_range(0, max_gap)) idle();
    endtask

    // idle until every issued instruction has written back
    task automatic drain();
        int unsigned waited;
        waited = 0;
        while (busy_cycles > 0) begin
            if (waited >= DRAIN_TIMEOUT) begin
                fail_run("timeout: instruction pipeline did not empty");
            end
            idle();
            waited++;
        end
    endtask

    // 64 random vectors, eight words each, lowest word first
    task automatic load_items();
        logic [`HV_DIM-1:0]  vec;
        logic [`HV_WORD-1:0] w;
        com_req = 1'b1;
        idle();
        for (int a = 0; a < `HV_ITEMS; a++) begin
            for (int k = 0; k < `HV_WORDS; k++) begin
                w = $urandom();
                vec[k*`HV_WORD +: `HV_WORD] = w;
                tick(1'b1, w, 1'b0, OP_NOP, '0);
                random_gap(2);
            end
            model_item[a] = vec;
        end
        // let the last write strobe reach the memory
        repeat (3) idle();
        com_req = 1'b0;
        idle();
    endtask

    task automatic random_op();
        logic [`HV_ARG_W-1:0] arg;
        arg = $urandom();
        case ($urandom_range(0, 9))
            0, 1, 2: issue(OP_ROT, arg);
            3:       issue(OP_COPY, arg);
            4, 5:    issue(OP_BIND, arg);
            6, 7:    issue(OP_STORE, arg);
            8:       issue(OP_LAST, arg);
            default: begin
                if (arg[0]) begin
                    issue(OP_LOAD, arg);
                end else begin
                    issue(OP_NOP, arg);
                end
            end
        endcase
    endtask

    initial begin
        logic [`HV_ADDR_W-1:0] base;
        void'($urandom(32'hca359391));
        arst_n      = 1'b0;
        com         = 1'b0;
        word_valid  = 1'b0;
        word_data   = '0;
        run         = 1'b0;
        inst_valid  = 1'b0;
        inst        = '{op: OP_NOP, arg: '0};
        com_req     = 1'b0;
        run_req     = 1'b0;
        busy_cycles = 0;
        model_thread = 0;
        repeat (3) exp_q.push_back('0);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        load_items();

        // item readback, load then store on the same thread
        run_req = 1'b1;
        for (int i = 0; i < 20; i++) begin
            issue(OP_LOAD, $urandom());
            for (int k = 0; k < `HV_THREADS - 1; k++) begin
                random_gap(2);
                issue(OP_NOP, $urandom());
            end
            issue(OP_STORE, '0);
            random_gap(3);
        end
        drain();

        // five loads in flight, each thread keeps its own
        for (int i = 0; i < 4; i++) begin
            base = $urandom();
            for (int k = 0; k < `HV_THREADS; k++) begin
                issue(OP_LOAD, `HV_ARG_W'(base + k * 7));
            end
            for (int k = 0; k < `HV_THREADS; k++) begin
                issue(OP_STORE, '0);
            end
            issue(OP_LAST, '0);
            random_gap(4);
        end
        drain();

        // every thread gets a known acc and aux before random ops
        for (int k = 0; k < `HV_THREADS; k++) begin
            issue(OP_LOAD, $urandom());
        end
        for (int k = 0; k < `HV_THREADS; k++) begin
            issue(OP_COPY, '0);
        end
        for (int i = 0; i < 300; i++) begin
            random_op();
            random_gap(1);
        end
        drain();

        // run restarts, thread 0 first, registers kept
        for (int r = 0; r < 8; r++) begin
            run_req = 1'b0;
            repeat ($urandom_range(1, 4)) idle();
            run_req = 1'b1;
            for (int k = 0; k < `HV_THREADS; k++) begin
                issue(OP_STORE, '0);
            end
            repeat ($urandom_range(1, 23)) begin
                random_op();
                random_gap(1);
            end
            drain();
        end

        run_req = 1'b0;
        repeat (4) idle();

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
hv_pkg.sv
hv_item_loader.sv
hv_item_memory.sv
hv_exec_core.sv
hv_core_top.sv
tb_hv_core.sv

// ==== Makefile ====
# Verilator simulation of the hyperdimensional core

TOP := tb_hv_core
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
